// File: project.f
glb_geom_pkg.sv
glb_port_pkg.sv
glb_addr_decode.sv
glb_bank_array.sv
glb_port_status.sv
glb_top.sv
glb_checker.sv
tb_glb.sv

// File: run.sh
#!/bin/sh
# Build and run the global buffer testbench with Verilator
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_glb -f project.f \
    -o sim_glb > sim.log 2>&1 \
    && ./obj_dir/sim_glb +verilator+error+limit+1000 >> sim.log 2>&1
cat sim.log
grep -q "^Everything OK$" sim.log && ! grep -q "%Error" sim.log \
    && echo "PASS" && exit 0 \
    || { echo "FAIL"; exit 1; }

// File: tb_glb.sv
`timescale 1ns/1ps
/*
 * Testbench for glb_top
 * Checks are done by the bound glb_checker
 * Port 0 of each direction carries the data traffic
 * Bank masks change only while rst_n is low
 */
module tb_glb;

    localparam int NW          = glb_port_pkg::NUM_WR;
    localparam int NR          = glb_port_pkg::NUM_RD;
    localparam int NB          = glb_geom_pkg::NUM_BANK;
    localparam int AW          = glb_geom_pkg::ADDR_W;
    localparam int DW          = glb_geom_pkg::DATA_W;
    localparam int VLD_TIMEOUT = 8;

    logic                   clk;
    logic                   rst_n;
    logic [NW-1:0][NB-1:0]  cfg_wr_mask;
    logic [NR-1:0][NB-1:0]  cfg_rd_mask;
    logic [NW-1:0]          wr_vld;
    logic [NW-1:0][AW-1:0]  wr_addr;
    logic [NW-1:0][DW-1:0]  wr_data;
    logic [NR-1:0]          rd_vld;
    logic [NR-1:0][AW-1:0]  rd_addr;
    logic [NW-1:0]          wr_full;
    logic [NR-1:0]          rd_empty;
    logic [NR-1:0][DW-1:0]  rd_data;
    logic [NR-1:0]          rd_data_vld;

    // Expected words by port 0 address, and status expectations
    logic [DW-1:0] exp_mem [64];
    logic          chk_full;
    logic          exp_full;
    logic          chk_empty;
    logic          exp_empty;
    logic [31:0]   lfsr;
    int            err_cnt;
    int            test_cnt;
    int            prev_fail;
    int            total;

    glb_top dut0 (
        .clk           (clk),
        .rst_n         (rst_n),
        .cfg_wr_mask_i (cfg_wr_mask),
        .cfg_rd_mask_i (cfg_rd_mask),
        .wr_vld_i      (wr_vld),
        .wr_addr_i     (wr_addr),
        .wr_data_i     (wr_data),
        .rd_vld_i      (rd_vld),
        .rd_addr_i     (rd_addr),
        .wr_full_o     (wr_full),
        .rd_empty_o    (rd_empty),
        .rd_data_o     (rd_data),
        .rd_data_vld_o (rd_data_vld)
    );

    bind glb_top glb_checker u_chk (
        .clk           (clk),
        .rst_n         (rst_n),
        .cfg_rd_mask_i (cfg_rd_mask_i),
        .rd_vld_i      (rd_vld_i),
        .rd_addr_i     (rd_addr_i),
        .rd_empty_i    (rd_empty_o),
        .rd_data_i     (rd_data_o),
        .rd_data_vld_i (rd_data_vld_o),
        .wr_full_i     (wr_full_o)
    );

    always #4 clk = ~clk;

    // ======================================================================
    // Helpers
    // ======================================================================
    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_bits(output logic [15:0] v);
        v = '0;
        for (int i = 0; i < 16; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[14:0], lfsr[0]};
        end
    endtask

    task automatic step_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic apply_reset(input logic [NB-1:0] wm0, input logic [NB-1:0] wm1,
                               input logic [NB-1:0] rm0, input logic [NB-1:0] rm1);
        rst_n          = 1'b0;
        wr_vld         = '0;
        rd_vld         = '0;
        cfg_wr_mask[0] = wm0;
        cfg_wr_mask[1] = wm1;
        cfg_rd_mask[0] = rm0;
        cfg_rd_mask[1] = rm1;
        repeat (8) step_cycle();
        rst_n = 1'b1;
    endtask

    // Word is {port, address} over random low bits
    task automatic set_write(input int p, input logic [AW-1:0] addr, input logic accept);
        logic [15:0] rnd;
        draw_bits(rnd);
        wr_vld[p]  = 1'b1;
        wr_addr[p] = addr;
        wr_data[p] = {p[7:0], addr, rnd};
        if (accept) begin
            exp_mem[addr[5:0]] = {p[7:0], addr, rnd};
        end
    endtask

    task automatic write_word(input int p, input logic [AW-1:0] addr, input logic accept);
        set_write(p, addr, accept);
        step_cycle();
        wr_vld[p] = 1'b0;
    endtask

    task automatic read_word(input int p, input logic [AW-1:0] addr);
        int cnt;
        rd_vld[p]  = 1'b1;
        rd_addr[p] = addr;
        step_cycle();
        rd_vld[p] = 1'b0;
        cnt       = 0;
        while (!rd_data_vld[p] && cnt < VLD_TIMEOUT) begin
            step_cycle();
            cnt++;
        end
        if (!rd_data_vld[p]) begin
            $display("timeout: no read data on port %0d for address %0d", p, addr);
            err_cnt++;
        end
    endtask

    // Strobe that must be dropped
    task automatic strobe_read(input int p, input logic [AW-1:0] addr);
        rd_vld[p]  = 1'b1;
        rd_addr[p] = addr;
        step_cycle();
        rd_vld[p] = 1'b0;
        step_cycle();
    endtask

    task automatic check_full(input logic [AW-1:0] addr, input logic exp);
        wr_addr[0] = addr;
        chk_full   = 1'b1;
        exp_full   = exp;
        step_cycle();
        chk_full = 1'b0;
    endtask

    task automatic check_empty(input logic [AW-1:0] addr, input logic exp);
        rd_addr[0] = addr;
        chk_empty  = 1'b1;
        exp_empty  = exp;
        step_cycle();
        chk_empty = 1'b0;
    endtask

    task automatic end_test(input string name);
        // One idle cycle so the last returned word is checked in this test
        step_cycle();
        test_cnt++;
        total = err_cnt + dut0.u_chk.fail_cnt;
        if (total == prev_fail) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d failures", name, total - prev_fail);
        end
        prev_fail = total;
    endtask

    // ======================================================================
    // Tests
    // ======================================================================
    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        cfg_wr_mask = '0;
        cfg_rd_mask = '0;
        wr_vld      = '0;
        wr_addr     = '0;
        wr_data     = '0;
        rd_vld      = '0;
        rd_addr     = '0;
        chk_full    = 1'b0;
        exp_full    = 1'b0;
        chk_empty   = 1'b0;
        exp_empty   = 1'b0;
        lfsr        = 32'hfcf4;
        err_cnt     = 0;
        test_cnt    = 0;
        prev_fail   = 0;
        for (int i = 0; i < 64; i++) begin
            exp_mem[i] = '0;
        end

        // Banks 0 and 1 for port 0 give a span of 32
        apply_reset(4'b0011, 4'b0000, 4'b0011, 4'b0000);
        check_empty(8'd0, 1'b1);
        end_test("reset");

        for (int a = 0; a < 32; a++) begin
            write_word(0, AW'(a), 1'b1);
        end
        check_full(8'd31, 1'b0);
        check_full(8'd32, 1'b1);
        read_word(0, 8'd0);
        check_full(8'd32, 1'b0);
        check_full(8'd33, 1'b1);
        end_test("full");

        for (int a = 0; a < 32; a++) begin
            read_word(0, AW'(a));
        end
        end_test("read latency and data");

        check_empty(8'd31, 1'b0);
        check_empty(8'd32, 1'b1);
        strobe_read(0, 8'd32);
        end_test("empty");

        // Both write ports claim bank 2 and write in the same cycle
        apply_reset(4'b0100, 4'b0100, 4'b0100, 4'b0000);
        set_write(0, 8'd3, 1'b1);
        set_write(1, 8'd3, 1'b0);
        step_cycle();
        wr_vld = '0;
        read_word(0, 8'd3);
        end_test("ownership");

        apply_reset(4'b0011, 4'b0000, 4'b0011, 4'b0000);
        for (int a = 0; a < 4; a++) begin
            write_word(0, AW'(a), 1'b1);
        end
        for (int a = 0; a < 4; a++) begin
            write_word(1, AW'(a), 1'b0);
        end
        for (int a = 0; a < 4; a++) begin
            strobe_read(1, AW'(a));
        end
        for (int a = 0; a < 4; a++) begin
            read_word(0, AW'(a));
        end
        end_test("unallocated port");

        total = err_cnt + dut0.u_chk.fail_cnt;
        $display("tests %0d, failures %0d", test_cnt, total);
        if (total == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: glb_checker.sv
`timescale 1ns/1ps
/*
 * Assertions for glb_top, attached by bind
 * Expected words and status flags are read from the testbench scope tb_glb
 * Read data is checked on read port 0 only
 */
module glb_checker (
    input logic                                                        clk,
    input logic                                                        rst_n,
    input logic [glb_port_pkg::NUM_RD-1:0][glb_geom_pkg::NUM_BANK-1:0] cfg_rd_mask_i,
    input logic [glb_port_pkg::NUM_RD-1:0]                             rd_vld_i,
    input logic [glb_port_pkg::NUM_RD-1:0][glb_geom_pkg::ADDR_W-1:0]   rd_addr_i,
    input logic [glb_port_pkg::NUM_RD-1:0]                             rd_empty_i,
    input logic [glb_port_pkg::NUM_RD-1:0][glb_geom_pkg::DATA_W-1:0]   rd_data_i,
    input logic [glb_port_pkg::NUM_RD-1:0]                             rd_data_vld_i,
    input logic [glb_port_pkg::NUM_WR-1:0]                             wr_full_i
);

    int                              fail_cnt = 0;
    logic [glb_geom_pkg::ADDR_W-1:0] last_addr;
    logic [glb_geom_pkg::DATA_W-1:0] exp_word;
    logic                            chk_full;
    logic                            exp_full;
    logic                            chk_empty;
    logic                            exp_empty;

    // Address of the read that the returning word belongs to
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            last_addr <= '0;
        end else begin
            last_addr <= rd_addr_i[0];
        end
    end

    assign exp_word  = tb_glb.exp_mem[last_addr[5:0]];
    assign chk_full  = tb_glb.chk_full;
    assign exp_full  = tb_glb.exp_full;
    assign chk_empty = tb_glb.chk_empty;
    assign exp_empty = tb_glb.exp_empty;

    // ======================================================================
    // Reset state
    // ======================================================================
    a_reset_empty: assert property (@(posedge clk) $rose(rst_n) |-> rd_empty_i == '1)
        else begin
            fail_cnt = fail_cnt + 1;
            $error("error rd_empty_o got %h exp %h", rd_empty_i, 2'h3);
        end

    a_reset_vld: assert property (@(posedge clk) $rose(rst_n) |-> rd_data_vld_i == '0)
        else begin
            fail_cnt = fail_cnt + 1;
            $error("error rd_data_vld_o got %h exp %h", rd_data_vld_i, 2'h0);
        end

    // ======================================================================
    // Read return
    // ======================================================================
    a_rd_latency: assert property (@(posedge clk) disable iff (!rst_n)
        (rd_vld_i[0] && !rd_empty_i[0] && cfg_rd_mask_i[0] != '0) |=> rd_data_vld_i[0])
        else begin
            fail_cnt = fail_cnt + 1;
            $error("read port 0 accepted a read but no data came back one cycle later");
        end

    for (genvar p = 0; p < glb_port_pkg::NUM_RD; p++) begin : g_port
        // Valid only after a strobe that was made while not empty
        a_no_spurious: assert property (@(posedge clk) disable iff (!rst_n)
            rd_data_vld_i[p] |-> $past(rd_vld_i[p] && !rd_empty_i[p]))
            else begin
                fail_cnt = fail_cnt + 1;
                $error("read port %0d returned data without an accepted read", p);
            end
    end

    a_rd_data: assert property (@(posedge clk) disable iff (!rst_n)
        rd_data_vld_i[0] |-> rd_data_i[0] == exp_word)
        else begin
            fail_cnt = fail_cnt + 1;
            $error("error rd_data_o[0] got %h exp %h", rd_data_i[0], exp_word);
        end

    // ======================================================================
    // Full and empty status
    // ======================================================================
    a_full: assert property (@(posedge clk) disable iff (!rst_n)
        chk_full |-> wr_full_i[0] == exp_full)
        else begin
            fail_cnt = fail_cnt + 1;
            $error("error wr_full_o[0] got %h exp %h", wr_full_i[0], exp_full);
        end

    a_empty: assert property (@(posedge clk) disable iff (!rst_n)
        chk_empty |-> rd_empty_i[0] == exp_empty)
        else begin
            fail_cnt = fail_cnt + 1;
            $error("error rd_empty_o[0] got %h exp %h", rd_empty_i[0], exp_empty);
        end

endmodule

// File: glb_top.sv
`timescale 1ns/1ps
/*
 * Banked global buffer, two write and two read ports over four banks
 * Bank masks are static and may only change while rst_n is low
 * Read data returns one cycle after an accepted read strobe
 */
module glb_top (
    input  logic                                                        clk,
    input  logic                                                        rst_n,
    input  logic [glb_port_pkg::NUM_WR-1:0][glb_geom_pkg::NUM_BANK-1:0] cfg_wr_mask_i,
    input  logic [glb_port_pkg::NUM_RD-1:0][glb_geom_pkg::NUM_BANK-1:0] cfg_rd_mask_i,
    input  logic [glb_port_pkg::NUM_WR-1:0]                             wr_vld_i,
    input  logic [glb_port_pkg::NUM_WR-1:0][glb_geom_pkg::ADDR_W-1:0]   wr_addr_i,
    input  logic [glb_port_pkg::NUM_WR-1:0][glb_geom_pkg::DATA_W-1:0]   wr_data_i,
    input  logic [glb_port_pkg::NUM_RD-1:0]                             rd_vld_i,
    input  logic [glb_port_pkg::NUM_RD-1:0][glb_geom_pkg::ADDR_W-1:0]   rd_addr_i,
    output logic [glb_port_pkg::NUM_WR-1:0]                             wr_full_o,
    output logic [glb_port_pkg::NUM_RD-1:0]                             rd_empty_o,
    output logic [glb_port_pkg::NUM_RD-1:0][glb_geom_pkg::DATA_W-1:0]   rd_data_o,
    output logic [glb_port_pkg::NUM_RD-1:0]                             rd_data_vld_o
);

    logic [glb_port_pkg::NUM_WR-1:0][glb_geom_pkg::BANK_IDX_W-1:0]  wr_bank;
    logic [glb_port_pkg::NUM_WR-1:0][glb_geom_pkg::ROW_W-1:0]       wr_row;
    logic [glb_port_pkg::NUM_WR-1:0][glb_geom_pkg::SPAN_W-1:0]      wr_span;
    logic [glb_port_pkg::NUM_RD-1:0][glb_geom_pkg::BANK_IDX_W-1:0]  rd_bank;
    logic [glb_port_pkg::NUM_RD-1:0][glb_geom_pkg::ROW_W-1:0]       rd_row;
    logic [glb_port_pkg::NUM_RD-1:0][glb_geom_pkg::SPAN_W-1:0]      rd_span;
    logic [glb_port_pkg::NUM_WR-1:0]                                wr_en;
    logic [glb_port_pkg::NUM_RD-1:0]                                rd_en;
    logic [glb_geom_pkg::NUM_BANK-1:0][glb_geom_pkg::DATA_W-1:0]    bank_rdata;
    logic [glb_geom_pkg::NUM_BANK-1:0][glb_geom_pkg::ADDR_W-1:0]    bank_wr_addr;
    logic [glb_geom_pkg::NUM_BANK-1:0]                              bank_written;
    logic [glb_geom_pkg::NUM_BANK-1:0][glb_geom_pkg::ADDR_W-1:0]    bank_rd_addr;
    logic [glb_geom_pkg::NUM_BANK-1:0]                              bank_read;
    logic [glb_geom_pkg::NUM_BANK-1:0][glb_port_pkg::WR_IDX_W-1:0]  bank_wr_owner;
    logic [glb_geom_pkg::NUM_BANK-1:0][glb_port_pkg::RD_IDX_W-1:0]  bank_rd_owner;

    // ======================================================================
    // Address decode, one per port
    // ======================================================================
    glb_addr_decode u_wr_dec [glb_port_pkg::NUM_WR-1:0] (
        .cfg_mask_i (cfg_wr_mask_i),
        .addr_i     (wr_addr_i),
        .bank_o     (wr_bank),
        .row_o      (wr_row),
        .span_o     (wr_span)
    );

    glb_addr_decode u_rd_dec [glb_port_pkg::NUM_RD-1:0] (
        .cfg_mask_i (cfg_rd_mask_i),
        .addr_i     (rd_addr_i),
        .bank_o     (rd_bank),
        .row_o      (rd_row),
        .span_o     (rd_span)
    );

    // ======================================================================
    // Banks and port status
    // ======================================================================
    glb_bank_array u_banks (
        .clk             (clk),
        .rst_n           (rst_n),
        .cfg_wr_mask_i   (cfg_wr_mask_i),
        .cfg_rd_mask_i   (cfg_rd_mask_i),
        .wr_en_i         (wr_en),
        .wr_bank_i       (wr_bank),
        .wr_row_i        (wr_row),
        .wr_addr_i       (wr_addr_i),
        .wr_data_i       (wr_data_i),
        .rd_en_i         (rd_en),
        .rd_bank_i       (rd_bank),
        .rd_row_i        (rd_row),
        .rd_addr_i       (rd_addr_i),
        .bank_rdata_o    (bank_rdata),
        .bank_wr_addr_o  (bank_wr_addr),
        .bank_written_o  (bank_written),
        .bank_rd_addr_o  (bank_rd_addr),
        .bank_read_o     (bank_read),
        .bank_wr_owner_o (bank_wr_owner),
        .bank_rd_owner_o (bank_rd_owner)
    );

    glb_port_status u_status (
        .clk             (clk),
        .rst_n           (rst_n),
        .wr_vld_i        (wr_vld_i),
        .rd_vld_i        (rd_vld_i),
        .wr_addr_i       (wr_addr_i),
        .rd_addr_i       (rd_addr_i),
        .cfg_wr_mask_i   (cfg_wr_mask_i),
        .cfg_rd_mask_i   (cfg_rd_mask_i),
        .wr_bank_i       (wr_bank),
        .wr_span_i       (wr_span),
        .rd_bank_i       (rd_bank),
        .rd_span_i       (rd_span),
        .bank_wr_addr_i  (bank_wr_addr),
        .bank_written_i  (bank_written),
        .bank_rd_addr_i  (bank_rd_addr),
        .bank_read_i     (bank_read),
        .bank_wr_owner_i (bank_wr_owner),
        .bank_rd_owner_i (bank_rd_owner),
        .bank_rdata_i    (bank_rdata),
        .wr_en_o         (wr_en),
        .rd_en_o         (rd_en),
        .wr_full_o       (wr_full_o),
        .rd_empty_o      (rd_empty_o),
        .rd_data_o       (rd_data_o),
        .rd_data_vld_o   (rd_data_vld_o)
    );

endmodule

// File: glb_port_status.sv
`timescale 1ns/1ps
/*
 * Per-port full/empty, strobe gating and read-data return
 * Requests made while full, empty or not owning the bank are dropped
 * Watermarks compare raw port addresses, not wrapped ones
 */
module glb_port_status (
    input  logic                                                         clk,
    input  logic                                                         rst_n,
    input  logic [glb_port_pkg::NUM_WR-1:0]                              wr_vld_i,
    input  logic [glb_port_pkg::NUM_RD-1:0]                              rd_vld_i,
    input  logic [glb_port_pkg::NUM_WR-1:0][glb_geom_pkg::ADDR_W-1:0]    wr_addr_i,
    input  logic [glb_port_pkg::NUM_RD-1:0][glb_geom_pkg::ADDR_W-1:0]    rd_addr_i,
    input  logic [glb_port_pkg::NUM_WR-1:0][glb_geom_pkg::NUM_BANK-1:0]  cfg_wr_mask_i,
    input  logic [glb_port_pkg::NUM_RD-1:0][glb_geom_pkg::NUM_BANK-1:0]  cfg_rd_mask_i,
    input  logic [glb_port_pkg::NUM_WR-1:0][glb_geom_pkg::BANK_IDX_W-1:0] wr_bank_i,
    input  logic [glb_port_pkg::NUM_WR-1:0][glb_geom_pkg::SPAN_W-1:0]    wr_span_i,
    input  logic [glb_port_pkg::NUM_RD-1:0][glb_geom_pkg::BANK_IDX_W-1:0] rd_bank_i,
    input  logic [glb_port_pkg::NUM_RD-1:0][glb_geom_pkg::SPAN_W-1:0]    rd_span_i,
    input  logic [glb_geom_pkg::NUM_BANK-1:0][glb_geom_pkg::ADDR_W-1:0]  bank_wr_addr_i,
    input  logic [glb_geom_pkg::NUM_BANK-1:0]                            bank_written_i,
    input  logic [glb_geom_pkg::NUM_BANK-1:0][glb_geom_pkg::ADDR_W-1:0]  bank_rd_addr_i,
    input  logic [glb_geom_pkg::NUM_BANK-1:0]                            bank_read_i,
    input  logic [glb_geom_pkg::NUM_BANK-1:0][glb_port_pkg::WR_IDX_W-1:0] bank_wr_owner_i,
    input  logic [glb_geom_pkg::NUM_BANK-1:0][glb_port_pkg::RD_IDX_W-1:0] bank_rd_owner_i,
    input  logic [glb_geom_pkg::NUM_BANK-1:0][glb_geom_pkg::DATA_W-1:0]  bank_rdata_i,
    output logic [glb_port_pkg::NUM_WR-1:0]                              wr_en_o,
    output logic [glb_port_pkg::NUM_RD-1:0]                              rd_en_o,
    output logic [glb_port_pkg::NUM_WR-1:0]                              wr_full_o,
    output logic [glb_port_pkg::NUM_RD-1:0]                              rd_empty_o,
    output logic [glb_port_pkg::NUM_RD-1:0][glb_geom_pkg::DATA_W-1:0]    rd_data_o,
    output logic [glb_port_pkg::NUM_RD-1:0]                              rd_data_vld_o
);

    // ======================================================================
    // Write ports
    // ======================================================================
    for (genvar p = 0; p < glb_port_pkg::NUM_WR; p++) begin : g_wr
        logic [glb_geom_pkg::ADDR_W-1:0] hi_rd;
        logic [glb_geom_pkg::ADDR_W-1:0] bound;
        logic                            any_rd;
        logic                            owns;

        // Highest read watermark over owned banks
        always_comb begin
            hi_rd  = '0;
            any_rd = 1'b0;
            for (int b = 0; b < glb_geom_pkg::NUM_BANK; b++) begin
                if (cfg_wr_mask_i[p][b]) begin
                    if (bank_rd_addr_i[b] > hi_rd) begin
                        hi_rd = bank_rd_addr_i[b];
                    end
                    any_rd = any_rd | bank_read_i[b];
                end
            end
        end

        // One extra slot once a read has happened
        assign bound = glb_geom_pkg::ADDR_W'(wr_span_i[p]) + glb_geom_pkg::ADDR_W'(any_rd);
        assign wr_full_o[p] = (wr_addr_i[p] - hi_rd) >= bound;

        assign owns = cfg_wr_mask_i[p][wr_bank_i[p]]
                    & (bank_wr_owner_i[wr_bank_i[p]] == glb_port_pkg::WR_IDX_W'(p));
        assign wr_en_o[p] = wr_vld_i[p] & (wr_span_i[p] != '0) & ~wr_full_o[p] & owns;
    end

    // ======================================================================
    // Read ports
    // ======================================================================
    for (genvar p = 0; p < glb_port_pkg::NUM_RD; p++) begin : g_rd
        logic [glb_geom_pkg::ADDR_W-1:0]     hi_wr;
        logic                                any_wr;
        logic                                owns;
        logic                                vld_q;
        logic [glb_geom_pkg::BANK_IDX_W-1:0] bank_q;

        always_comb begin
            hi_wr  = '0;
            any_wr = 1'b0;
            for (int b = 0; b < glb_geom_pkg::NUM_BANK; b++) begin
                if (cfg_rd_mask_i[p][b]) begin
                    if (bank_wr_addr_i[b] > hi_wr) begin
                        hi_wr = bank_wr_addr_i[b];
                    end
                    any_wr = any_wr | bank_written_i[b];
                end
            end
        end

        assign rd_empty_o[p] = ~any_wr | (rd_addr_i[p] > hi_wr);

        assign owns = cfg_rd_mask_i[p][rd_bank_i[p]]
                    & (bank_rd_owner_i[rd_bank_i[p]] == glb_port_pkg::RD_IDX_W'(p));
        assign rd_en_o[p] = rd_vld_i[p] & (rd_span_i[p] != '0) & ~rd_empty_o[p] & owns;

        // Remember which bank register carries this port's word
        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                vld_q  <= 1'b0;
                bank_q <= '0;
            end else begin
                vld_q <= rd_en_o[p];
                if (rd_en_o[p]) begin
                    bank_q <= rd_bank_i[p];
                end
            end
        end

        assign rd_data_vld_o[p] = vld_q;
        assign rd_data_o[p]     = bank_rdata_i[bank_q];
    end

endmodule

// File: glb_bank_array.sv
`timescale 1ns/1ps
/*
 * Four single-port banks with watermarks
 * Only the lowest-indexed claiming port of a direction touches a bank
 * Read data is registered per bank and holds until the next read
 */
module glb_bank_array (
    input  logic                                                         clk,
    input  logic                                                         rst_n,
    input  logic [glb_port_pkg::NUM_WR-1:0][glb_geom_pkg::NUM_BANK-1:0]  cfg_wr_mask_i,
    input  logic [glb_port_pkg::NUM_RD-1:0][glb_geom_pkg::NUM_BANK-1:0]  cfg_rd_mask_i,
    input  logic [glb_port_pkg::NUM_WR-1:0]                              wr_en_i,
    input  logic [glb_port_pkg::NUM_WR-1:0][glb_geom_pkg::BANK_IDX_W-1:0] wr_bank_i,
    input  logic [glb_port_pkg::NUM_WR-1:0][glb_geom_pkg::ROW_W-1:0]     wr_row_i,
    input  logic [glb_port_pkg::NUM_WR-1:0][glb_geom_pkg::ADDR_W-1:0]    wr_addr_i,
    input  logic [glb_port_pkg::NUM_WR-1:0][glb_geom_pkg::DATA_W-1:0]    wr_data_i,
    input  logic [glb_port_pkg::NUM_RD-1:0]                              rd_en_i,
    input  logic [glb_port_pkg::NUM_RD-1:0][glb_geom_pkg::BANK_IDX_W-1:0] rd_bank_i,
    input  logic [glb_port_pkg::NUM_RD-1:0][glb_geom_pkg::ROW_W-1:0]     rd_row_i,
    input  logic [glb_port_pkg::NUM_RD-1:0][glb_geom_pkg::ADDR_W-1:0]    rd_addr_i,
    output logic [glb_geom_pkg::NUM_BANK-1:0][glb_geom_pkg::DATA_W-1:0]  bank_rdata_o,
    output logic [glb_geom_pkg::NUM_BANK-1:0][glb_geom_pkg::ADDR_W-1:0]  bank_wr_addr_o,
    output logic [glb_geom_pkg::NUM_BANK-1:0]                            bank_written_o,
    output logic [glb_geom_pkg::NUM_BANK-1:0][glb_geom_pkg::ADDR_W-1:0]  bank_rd_addr_o,
    output logic [glb_geom_pkg::NUM_BANK-1:0]                            bank_read_o,
    output logic [glb_geom_pkg::NUM_BANK-1:0][glb_port_pkg::WR_IDX_W-1:0] bank_wr_owner_o,
    output logic [glb_geom_pkg::NUM_BANK-1:0][glb_port_pkg::RD_IDX_W-1:0] bank_rd_owner_o
);

    for (genvar b = 0; b < glb_geom_pkg::NUM_BANK; b++) begin : g_bank
        logic [glb_geom_pkg::DATA_W-1:0]   mem [glb_geom_pkg::BANK_WORDS];
        logic [glb_geom_pkg::DATA_W-1:0]   rdata_q;
        logic [glb_port_pkg::WR_IDX_W-1:0] wr_own;
        logic [glb_port_pkg::RD_IDX_W-1:0] rd_own;
        logic                              we;
        logic                              re;
        logic [glb_geom_pkg::ADDR_W-1:0]   wr_addr_q;
        logic [glb_geom_pkg::ADDR_W-1:0]   rd_addr_q;
        logic                              written_q;
        logic                              read_q;

        // ==================================================================
        // Ownership, lowest port index wins
        // ==================================================================
        always_comb begin
            wr_own = '0;
            for (int p = glb_port_pkg::NUM_WR - 1; p >= 0; p--) begin
                if (cfg_wr_mask_i[p][b]) begin
                    wr_own = p[glb_port_pkg::WR_IDX_W-1:0];
                end
            end
        end

        always_comb begin
            rd_own = '0;
            for (int p = glb_port_pkg::NUM_RD - 1; p >= 0; p--) begin
                if (cfg_rd_mask_i[p][b]) begin
                    rd_own = p[glb_port_pkg::RD_IDX_W-1:0];
                end
            end
        end

        // Owner must also aim at this bank
        assign we = wr_en_i[wr_own] & cfg_wr_mask_i[wr_own][b]
                  & (wr_bank_i[wr_own] == glb_geom_pkg::BANK_IDX_W'(b));
        assign re = rd_en_i[rd_own] & cfg_rd_mask_i[rd_own][b]
                  & (rd_bank_i[rd_own] == glb_geom_pkg::BANK_IDX_W'(b));

        // ==================================================================
        // Storage and read register
        // ==================================================================
        always_ff @(posedge clk) begin
            if (we) begin
                mem[wr_row_i[wr_own]] <= wr_data_i[wr_own];
            end
            if (re) begin
                rdata_q <= mem[rd_row_i[rd_own]];
            end
        end

        // Watermarks hold the raw port address of the last access
        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                wr_addr_q <= '0;
                written_q <= 1'b0;
                rd_addr_q <= '0;
                read_q    <= 1'b0;
            end else begin
                if (we) begin
                    wr_addr_q <= wr_addr_i[wr_own];
                    written_q <= 1'b1;
                end
                if (re) begin
                    rd_addr_q <= rd_addr_i[rd_own];
                    read_q    <= 1'b1;
                end
            end
        end

        assign bank_rdata_o[b]    = rdata_q;
        assign bank_wr_addr_o[b]  = wr_addr_q;
        assign bank_written_o[b]  = written_q;
        assign bank_rd_addr_o[b]  = rd_addr_q;
        assign bank_read_o[b]     = read_q;
        assign bank_wr_owner_o[b] = wr_own;
        assign bank_rd_owner_o[b] = rd_own;
    end

endmodule

// File: glb_addr_decode.sv
`timescale 1ns/1ps
/*
 * Maps one port address onto its owned banks
 * A zero mask gives span 0 and bank/row are then don't-care
 * Banks are counted up from the lowest owned one, gaps are not skipped
 */
module glb_addr_decode (
    input  logic [glb_geom_pkg::NUM_BANK-1:0]   cfg_mask_i,
    input  logic [glb_geom_pkg::ADDR_W-1:0]     addr_i,
    output logic [glb_geom_pkg::BANK_IDX_W-1:0] bank_o,
    output logic [glb_geom_pkg::ROW_W-1:0]      row_o,
    output logic [glb_geom_pkg::SPAN_W-1:0]     span_o
);

    logic [glb_geom_pkg::BANK_IDX_W-1:0]                  first_bank;
    logic [glb_geom_pkg::SPAN_W-glb_geom_pkg::ROW_W-1:0] num_bank;
    logic [glb_geom_pkg::ADDR_W-1:0]                      offs;

    // Lowest owned bank and number of owned banks
    always_comb begin
        first_bank = '0;
        num_bank   = '0;
        for (int b = glb_geom_pkg::NUM_BANK - 1; b >= 0; b--) begin
            if (cfg_mask_i[b]) begin
                first_bank = b[glb_geom_pkg::BANK_IDX_W-1:0];
                num_bank   = num_bank + 1;
            end
        end
    end

    // Span in words
    assign span_o = {num_bank, {glb_geom_pkg::ROW_W{1'b0}}};

    // Wrap inside the port's own space
    assign offs   = (span_o == '0) ? '0 : addr_i % span_o;
    assign row_o  = offs[glb_geom_pkg::ROW_W-1:0];
    assign bank_o = first_bank + offs[glb_geom_pkg::ROW_W +: glb_geom_pkg::BANK_IDX_W];

endmodule

// File: glb_port_pkg.sv
/*
 * Port counts of the global buffer
 * Index widths assume two ports per direction
 */
package glb_port_pkg;

    // ======================================================================
    // Port side
    // ======================================================================
    localparam int NUM_WR   = 2;
    localparam int NUM_RD   = 2;
    localparam int WR_IDX_W = 1;
    localparam int RD_IDX_W = 1;

endpackage

// File: glb_geom_pkg.sv
/*
 * Storage geometry of the global buffer
 * BANK_WORDS must stay a power of two so that a row is a plain bit field
 * SPAN_W must hold NUM_BANK * BANK_WORDS
 */
package glb_geom_pkg;

    // ======================================================================
    // Bank geometry
    // ======================================================================
    localparam int NUM_BANK   = 4;
    localparam int BANK_WORDS = 16;
    localparam int ROW_W      = $clog2(BANK_WORDS);
    localparam int BANK_IDX_W = $clog2(NUM_BANK);

    // ======================================================================
    // Word and address widths
    // ======================================================================
    localparam int DATA_W = 32;
    localparam int ADDR_W = 8;
    // Largest span is all banks at once, 64 words
    localparam int SPAN_W = 7;

endpackage
